/* alu_uart_top.f */
hdl/alu_uart_pkg.sv
hdl/baud_tick_gen.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/alu.sv
hdl/interface_circuit.sv
hdl/alu_uart_top.sv
tests/alu_uart_top_tb.sv

/* hdl/alu.sv */
module alu (
    input  alu_uart_pkg::alu_request_t i_request,
    output alu_uart_pkg::word_t        o_result
);
    import alu_uart_pkg::*;

    word_t  a;
    word_t  b;
    shamt_t shamt;

    assign a     = i_request.operand_a;
    assign b     = i_request.operand_b;
    assign shamt = i_request.operand_b[BIT_W-1:0];  // Upper bits of B ignored.

    //////////////////////////////////////////////////
    // Opcode decode.
    //////////////////////////////////////////////////
    always_comb begin
        case (i_request.opcode)
            OP_ADD: o_result = a + b;               // Wraps with no carry out.
            OP_SUB: o_result = a - b;
            OP_AND: o_result = a & b;
            OP_OR: begin
                o_result = a | b;
            end
            OP_XOR: o_result = a ^ b;
            OP_NOR: o_result = ~(a | b);
            OP_SRL: o_result = a >> shamt;
            OP_SRA: begin
                // Sign of A fills from the top.
                o_result = word_t'($signed(a) >>> shamt);
            end
            default: o_result = '0;
        endcase
    end

endmodule

/* hdl/alu_uart_pkg.sv */
package alu_uart_pkg;

    //////////////////////////////////////////////////
    // Widths and line timing.
    //////////////////////////////////////////////////
    localparam int DATA_BITS    = 8;     // Payload bits per frame.
    localparam int BAUD_DIVIDER = 2;     // Clocks per oversampling tick.
    localparam int OVERSAMPLE   = 16;    // Ticks per bit.

    localparam int BAUD_W = $clog2(BAUD_DIVIDER);
    localparam int TICK_W = $clog2(OVERSAMPLE);
    localparam int BIT_W  = $clog2(DATA_BITS);

    typedef logic [DATA_BITS-1:0] word_t;        // Line byte, operand or result.
    typedef logic [7:0]           opcode_t;
    typedef logic [BAUD_W-1:0]    baud_count_t;
    typedef logic [TICK_W-1:0]    tick_count_t;  // Ticks within one bit.
    typedef logic [BIT_W-1:0]     bit_count_t;   // Data bit index.
    typedef logic [BIT_W-1:0]     shamt_t;       // Shift amount.

    //////////////////////////////////////////////////
    // Opcodes.
    //////////////////////////////////////////////////
    localparam opcode_t OP_ADD = 8'h20;
    localparam opcode_t OP_SUB = 8'h22;
    localparam opcode_t OP_AND = 8'h24;
    localparam opcode_t OP_OR  = 8'h25;
    localparam opcode_t OP_XOR = 8'h26;
    localparam opcode_t OP_NOR = 8'h27;
    localparam opcode_t OP_SRL = 8'h02;
    localparam opcode_t OP_SRA = 8'h03;

    // One complete ALU command.
    typedef struct packed {
        opcode_t opcode;
        word_t   operand_a;
        word_t   operand_b;
    } alu_request_t;

    //////////////////////////////////////////////////
    // State machines.
    //////////////////////////////////////////////////
    typedef enum logic [2:0] {
        WAIT_A,
        WAIT_OP,
        WAIT_B,
        LAUNCH,
        WAIT_TX
    } seq_state_t;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

endpackage

/* hdl/alu_uart_top.sv */
module alu_uart_top (
    input  logic i_clock,
    input  logic i_reset,
    input  logic i_uart_rx,
    output logic o_uart_tx
);
    import alu_uart_pkg::*;

    logic         tick;
    word_t        rx_data;
    logic         rx_done;
    alu_request_t request;
    word_t        result;
    logic         tx_start;
    word_t        tx_data;
    logic         tx_done;

    // Shared by both directions.
    baud_tick_gen baud_tick_gen_inst (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .o_tick  (tick)
    );

    uart_rx uart_rx_inst (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_tick    (tick),
        .i_rx      (i_uart_rx),
        .o_data    (rx_data),
        .o_rx_done (rx_done)
    );

    interface_circuit interface_circuit_inst (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_rx_done  (rx_done),
        .i_data_rx  (rx_data),
        .i_result   (result),
        .i_tx_done  (tx_done),
        .o_request  (request),
        .o_tx_start (tx_start),
        .o_data_tx  (tx_data)
    );

    alu alu_inst (
        .i_request (request),
        .o_result  (result)
    );

    uart_tx uart_tx_inst (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_tick     (tick),
        .i_tx_start (tx_start),
        .i_data     (tx_data),
        .o_tx       (o_uart_tx),
        .o_tx_done  (tx_done)
    );

endmodule

/* hdl/baud_tick_gen.sv */
module baud_tick_gen (
    input  logic i_clock,
    input  logic i_reset,
    output logic o_tick
);
    import alu_uart_pkg::*;

    baud_count_t count;

    // Free-running divider with one tick per wrap.
    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            count  <= '0;
            o_tick <= 1'b0;
        end else if (count == baud_count_t'(BAUD_DIVIDER - 1)) begin
            count  <= '0;
            o_tick <= 1'b1;
        end else begin
            count  <= count + 1'b1;
            o_tick <= 1'b0;
        end
    end

endmodule

/* hdl/interface_circuit.sv */
module interface_circuit (
    input  logic                       i_clock,
    input  logic                       i_reset,
    input  logic                       i_rx_done,
    input  alu_uart_pkg::word_t        i_data_rx,
    input  alu_uart_pkg::word_t        i_result,
    input  logic                       i_tx_done,
    output alu_uart_pkg::alu_request_t o_request,
    output logic                       o_tx_start,
    output alu_uart_pkg::word_t        o_data_tx
);
    import alu_uart_pkg::*;

    seq_state_t state;

    //////////////////////////////////////////////////
    // Command sequencer.
    //////////////////////////////////////////////////
    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            state      <= WAIT_A;
            o_request  <= '0;
            o_tx_start <= 1'b0;
            o_data_tx  <= '0;
        end else begin
            o_tx_start <= 1'b0;
            case (state)
                WAIT_A: begin
                    if (i_rx_done) begin
                        o_request.operand_a <= i_data_rx;
                        state               <= WAIT_OP;
                    end
                end
                WAIT_OP: begin
                    if (i_rx_done) begin
                        o_request.opcode <= opcode_t'(i_data_rx);
                        state            <= WAIT_B;
                    end
                end
                WAIT_B: begin
                    if (i_rx_done) begin
                        o_request.operand_b <= i_data_rx;
                        o_tx_start          <= 1'b1;     // High for the LAUNCH cycle.
                        state               <= LAUNCH;
                    end
                end
                LAUNCH: begin
                    // Request is complete and the ALU output has settled.
                    o_data_tx <= i_result;
                    state     <= WAIT_TX;
                end
                WAIT_TX: begin
                    // Bytes arriving now are lost.
                    if (i_tx_done) state <= WAIT_A;
                end
                default: state <= WAIT_A;
            endcase
        end
    end

endmodule

/* hdl/uart_rx.sv */
module uart_rx (
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_tick,
    input  logic                i_rx,
    output alu_uart_pkg::word_t o_data,
    output logic                o_rx_done
);
    import alu_uart_pkg::*;

    rx_state_t   state;
    logic [1:0]  rx_sync;      // Line synchronizer.
    logic        rx_line;
    logic        bit_end;      // Last tick of a bit period.
    tick_count_t tick_count;
    bit_count_t  bit_count;
    word_t       shift;

    assign rx_line = rx_sync[1];
    assign bit_end = i_tick && (tick_count == tick_count_t'(OVERSAMPLE - 1));

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            rx_sync <= 2'b11;      // Idle line is high.
        end else begin
            rx_sync <= {rx_sync[0], i_rx};
        end
    end

    //////////////////////////////////////////////////
    // Frame FSM.
    //////////////////////////////////////////////////
    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            state      <= RX_IDLE;
            tick_count <= '0;
            bit_count  <= '0;
            o_rx_done  <= 1'b0;
        end else begin
            o_rx_done <= 1'b0;
            if (i_tick && state != RX_IDLE) tick_count <= tick_count + 1'b1;
            case (state)
                RX_IDLE: begin
                    tick_count <= '0;
                    if (!rx_line) state <= RX_START;
                end
                RX_START: begin
                    // Half a bit in, recheck the line.
                    if (i_tick && tick_count == tick_count_t'(OVERSAMPLE / 2 - 1)) begin
                        tick_count <= '0;
                        bit_count  <= '0;
                        state      <= rx_line ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        bit_count <= bit_count + 1'b1;
                        if (bit_count == bit_count_t'(DATA_BITS - 1)) state <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        o_rx_done <= rx_line;  // Low stop bit drops the frame.
                        state     <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Payload shifts in LSB first.
    always_ff @(posedge i_clock) begin
        if (state == RX_DATA && bit_end) shift <= {rx_line, shift[DATA_BITS-1:1]};
        if (state == RX_STOP && bit_end && rx_line) o_data <= shift;
    end

endmodule

/* hdl/uart_tx.sv */
module uart_tx (
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_tick,
    input  logic                i_tx_start,
    input  alu_uart_pkg::word_t i_data,
    output logic                o_tx,
    output logic                o_tx_done
);
    import alu_uart_pkg::*;

    tx_state_t   state;
    logic        bit_end;
    tick_count_t tick_count;
    bit_count_t  bit_count;
    word_t       shift;

    assign bit_end = i_tick && (tick_count == tick_count_t'(OVERSAMPLE - 1));

    //////////////////////////////////////////////////
    // Frame FSM and line driver.
    //////////////////////////////////////////////////
    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            state      <= TX_IDLE;
            tick_count <= '0;
            bit_count  <= '0;
            o_tx       <= 1'b1;
            o_tx_done  <= 1'b0;
        end else begin
            o_tx_done <= 1'b0;
            if (i_tick) tick_count <= tick_count + 1'b1;
            case (state)
                TX_IDLE: begin
                    tick_count <= '0;
                    if (i_tx_start) begin
                        o_tx  <= 1'b0;       // Start bit.
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        bit_count <= '0;
                        o_tx      <= i_data[0];
                        state     <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        bit_count <= bit_count + 1'b1;
                        if (bit_count == bit_count_t'(DATA_BITS - 1)) begin
                            o_tx  <= 1'b1;   // Stop bit.
                            state <= TX_STOP;
                        end else begin
                            o_tx <= shift[1];
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_end) begin
                        o_tx_done <= 1'b1;
                        state     <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Sequencer holds the byte for the whole frame.
    always_ff @(posedge i_clock) begin
        if (state == TX_START && bit_end) shift <= i_data;
        else if (state == TX_DATA && bit_end) shift <= shift >> 1;
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module alu_uart_top_tb -f alu_uart_top.f --Mdir obj_dir

output=$(./obj_dir/Valu_uart_top_tb 2>&1 || true)
echo "$output"

if echo "$output" | grep -q "^TEST PASSED$"; then
    exit 0
else
    exit 1
fi

/* tests/alu_uart_top_tb.sv */
module alu_uart_top_tb;
    import alu_uart_pkg::*;

    localparam int BIT_CLOCKS    = BAUD_DIVIDER * OVERSAMPLE;  // Clocks per serial bit.
    localparam int REPLY_TIMEOUT = 4000;                       // Clocks to wait for a reply.

    // One command with its framing option.
    typedef struct packed {
        word_t   operand_a;
        opcode_t opcode;
        word_t   operand_b;
        logic    bad_stop;
    } vector_t;

    logic        clock;
    logic        reset;
    logic        uart_rx;
    logic        uart_tx;
    logic [31:0] lfsr_state;
    vector_t     vectors[$];

    alu_uart_top alu_uart_top_inst (
        .i_clock   (clock),
        .i_reset   (reset),
        .i_uart_rx (uart_rx),
        .o_uart_tx (uart_tx)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    //////////////////////////////////////////////////
    // Checking and reference model.
    //////////////////////////////////////////////////
    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped on error.");
    endtask

    task automatic check_value(input word_t got, input word_t expected, input string what);
        if (got !== expected) begin
            $display("FAILED at %0t: %s, got 0x%02h, expected 0x%02h",
                     $time, what, got, expected);
            abort_run();
        end
    endtask

    function automatic word_t model_result(word_t a, opcode_t op, word_t b);
        int    amount;
        word_t result;
        amount = int'(b[2:0]);  // Only the low three bits of B.
        case (op)
            OP_ADD: result = a + b;
            OP_SUB: result = a - b;
            OP_AND: result = a & b;
            OP_OR:  result = a | b;
            OP_XOR: result = a ^ b;
            OP_NOR: result = ~(a | b);
            OP_SRL: result = a >> amount;
            OP_SRA: begin
                result = a >> amount;
                if (a[7]) result = result | ~(8'hFF >> amount);  // Copy sign bit.
            end
            default: result = 8'h00;
        endcase
        return result;
    endfunction

    // Fibonacci LFSR with taps 32 22 2 1.
    function automatic word_t random_byte();
        word_t value;
        logic  feedback;
        int    i;
        value = '0;
        for (i = 0; i < 8; i++) begin
            feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            value      = {value[6:0], feedback};
        end
        return value;
    endfunction

    //////////////////////////////////////////////////
    // Serial driver and monitor.
    //////////////////////////////////////////////////
    task automatic drive_line(input logic level, input int clocks);
        @(posedge clock);
        #1 uart_rx = level;
        repeat (clocks - 1) @(posedge clock);
    endtask

    task automatic send_frame(input word_t data, input logic bad_stop);
        int i;
        drive_line(1'b0, BIT_CLOCKS);
        for (i = 0; i < DATA_BITS; i++) drive_line(data[i], BIT_CLOCKS);
        if (bad_stop) begin
            // Low past the receiver's mid-bit sample, then idle.
            drive_line(1'b0, BIT_CLOCKS * 3 / 4);
            drive_line(1'b1, BIT_CLOCKS);
        end else begin
            drive_line(1'b1, BIT_CLOCKS);
        end
    endtask

    task automatic send_command(input vector_t v);
        send_frame(v.operand_a, 1'b0);
        if (v.bad_stop) send_frame(v.opcode, 1'b1);  // Must be dropped.
        send_frame(v.opcode, 1'b0);
        send_frame(v.operand_b, 1'b0);
    endtask

    task automatic receive_byte(output word_t value);
        int waited;
        int i;
        waited = 0;
        do begin
            @(negedge clock);
            waited++;
        end while (uart_tx !== 1'b0 && waited < REPLY_TIMEOUT);
        if (uart_tx !== 1'b0) begin
            $display("Timed out waiting, no start bit from DUT.");
            abort_run();
        end
        repeat (BIT_CLOCKS / 2) @(negedge clock);  // Middle of the start bit.
        check_value({7'b0, uart_tx}, 8'h00, "start bit low at mid-bit");
        for (i = 0; i < DATA_BITS; i++) begin
            repeat (BIT_CLOCKS) @(negedge clock);
            value[i] = uart_tx;
        end
        repeat (BIT_CLOCKS) @(negedge clock);
        check_value({7'b0, uart_tx}, 8'h01, "stop bit high");
    endtask

    //////////////////////////////////////////////////
    // Stimulus table.
    //////////////////////////////////////////////////
    task automatic add_vector(input word_t a, input opcode_t op, input word_t b, input logic bad);
        vector_t v;
        v.operand_a = a;
        v.opcode    = op;
        v.operand_b = b;
        v.bad_stop  = bad;
        vectors.push_back(v);
    endtask

    task automatic add_random_vector(input opcode_t op);
        word_t a;
        word_t b;
        a = random_byte();
        b = random_byte();
        add_vector(a, op, b, 1'b0);
    endtask

    task automatic build_table();
        add_vector(8'h05, OP_ADD, 8'h03, 1'b0);
        add_vector(8'hF0, OP_ADD, 8'h20, 1'b0);  // Wraps.
        add_random_vector(OP_ADD);
        add_vector(8'h10, OP_SUB, 8'h01, 1'b0);
        add_vector(8'h01, OP_SUB, 8'h02, 1'b0);  // Borrow wraps to 0xFF.
        add_random_vector(OP_SUB);
        add_random_vector(OP_AND);
        add_random_vector(OP_OR);
        add_random_vector(OP_XOR);
        add_random_vector(OP_NOR);
        add_vector(8'hB4, OP_SRL, 8'h0B, 1'b0);
        add_vector(8'hB4, OP_SRA, 8'h0A, 1'b0);
        add_vector(8'h74, OP_SRA, 8'hF9, 1'b0);
        add_vector(random_byte(), OP_SRL, 8'h0F, 1'b0);
        add_vector(8'h5A, 8'hFF, 8'h3C, 1'b0);   // Undefined opcode.
        add_vector(8'h12, OP_ADD, 8'h34, 1'b1);
    endtask

    initial begin
        int      n;
        word_t   got;
        vector_t v;
        reset      = 1'b0;
        uart_rx    = 1'b1;
        lfsr_state = 32'haf4fc5e8;
        repeat (3) @(posedge clock);
        #1 reset = 1'b1;

        // Line must stay idle with no command sent.
        repeat (100) begin
            @(negedge clock);
            check_value({7'b0, uart_tx}, 8'h01, "line idle after reset");
        end

        build_table();
        for (n = 0; n < vectors.size(); n++) begin
            v = vectors[n];
            fork
                send_command(v);
                receive_byte(got);
            join
            check_value(got, model_result(v.operand_a, v.opcode, v.operand_b),
                        $sformatf("vector %0d, opcode 0x%02h", n, v.opcode));
            repeat (BIT_CLOCKS) @(posedge clock);
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule
